// File: filelist.f
+incdir+testbench
hw/cpuPkg.sv
hw/flowSequencer.sv
hw/microcodeRom.sv
hw/registerFile.sv
hw/aluFlags.sv
hw/interruptControl.sv
hw/cpuCore.sv
testbench/tbCpuCore.sv

// File: Bender.yml
package:
  name: cpucore

sources:
  - files:
      - hw/cpuPkg.sv
      - hw/flowSequencer.sv
      - hw/microcodeRom.sv
      - hw/registerFile.sv
      - hw/aluFlags.sv
      - hw/interruptControl.sv
      - hw/cpuCore.sv
  - target: test
    include_dirs:
      - testbench
    files:
      - testbench/tbCpuCore.sv

// File: testbench/tbPrograms.svh
localparam int maxRows   = 16;
localparam int progBytes = 24;

localparam logic [3:0][7:0] aluOpcodes = {8'hA8, 8'hA0, 8'h90, 8'h80};

logic [7:0]  progMem    [maxRows][progBytes];
int          progLen    [maxRows];
int          pulseCycle [maxRows];  // -1 when no request pulse
logic [15:0] expAddr    [maxRows];
logic [7:0]  expData    [maxRows];
string       testName   [maxRows];
int          rowCount   = 0;
int          totalBytes = 0;
logic [31:0] lfsrState;

task automatic check(input string name, input logic [15:0] actual, input logic [15:0] expected);
  if (actual !== expected)
  begin
    errorCount++;
    $display("FAIL at %0t: %s = %h, expected %h", $time, name, actual, expected);
  end
endtask

// Galois form, taps 32,22,2,1
function automatic logic [31:0] lfsrStep(input logic [31:0] state);
  lfsrStep = state[0] ? ((state >> 1) ^ 32'h8020_0003) : (state >> 1);
endfunction

task automatic takeByte(output logic [7:0] value);
  int i;
  value = '0;
  for (i = 0; i < 8; i++)
  begin
    value = {value[6:0], lfsrState[0]};
    lfsrState = lfsrStep(lfsrState);
  end
endtask

function automatic logic [7:0] aluExpect(input logic [7:0] opcode, input logic [7:0] x, y);
  case (opcode)
    8'h80:   aluExpect = x + y;
    8'h90:   aluExpect = x - y;
    8'hA0:   aluExpect = x & y;
    default: aluExpect = x ^ y;
  endcase
endfunction

// Branch target stores 5Ah, fall-through stores A5h
function automatic logic [7:0] takenData(input logic taken);
  takenData = taken ? 8'h5A : 8'hA5;
endfunction

// Code bytes are right-aligned, first byte most significant
task automatic addRow(input string name, input logic [8*progBytes-1:0] code, input int len,
                      input int pulse, input logic [15:0] addr, input logic [7:0] data);
  int i;
  testName[rowCount]   = name;
  progLen[rowCount]    = len;
  pulseCycle[rowCount] = pulse;
  expAddr[rowCount]    = addr;
  expData[rowCount]    = data;
  for (i = 0; i < len; i++)
    progMem[rowCount][i] = code[8*(len-1-i) +: 8];
  rowCount++;
  totalBytes += len;
endtask

task automatic buildTable();
  logic [7:0] x, y, r, opc, mode0, mode1;
  int         k;
  lfsrState = 32'hb204_5e38;
  takeByte(x);
  addRow("load store", {8'h26, 8'h00, 8'h2E, 8'h9C, 8'h3E, x, 8'h77}, 7, -1, 16'h009C, x);
  for (k = 0; k < 4; k++)
  begin
    takeByte(x);
    takeByte(y);
    opc = aluOpcodes[k];
    addRow($sformatf("alu op %02h", opc),
           {8'h26, 8'h00, 8'h2E, 8'h9D, 8'h3E, x, 8'h06, y, opc, 8'h77}, 10, -1,
           16'h009D, aluExpect(opc, x, y));
  end
  // INC A then JP Z,000Dh
  for (k = 0; k < 2; k++)
  begin
    x = (k == 0) ? 8'hFF : 8'hFE;
    r = x + 8'd1;
    addRow($sformatf("jp z after inc %02h", x),
           {8'h26, 8'h00, 8'h2E, 8'h9E, 8'h3E, x, 8'h3C, 8'hCA, 8'h0D, 8'h00, 8'h3E, 8'hA5,
            8'h77, 8'h3E, 8'h5A, 8'h77}, 16, -1, 16'h009E, takenData(r == 8'h00));
  end
  // SUB B then JP C,000Fh
  for (k = 0; k < 2; k++)
  begin
    x = (k == 0) ? 8'h10 : 8'h30;
    y = 8'h20;
    addRow($sformatf("jp c after sub %02h-%02h", x, y),
           {8'h26, 8'h00, 8'h2E, 8'h9F, 8'h3E, x, 8'h06, y, 8'h90, 8'hDA, 8'h0F, 8'h00,
            8'h3E, 8'hA5, 8'h77, 8'h3E, 8'h5A, 8'h77}, 18, -1, 16'h009F, takenData(x < y));
  end
  addRow("jp skips store",
         {8'h26, 8'h00, 8'h2E, 8'hA0, 8'h3E, 8'hA5, 8'hC3, 8'h0B, 8'h00, 8'h77, 8'h00,
          8'h3E, 8'h5A, 8'h77}, 14, -1, 16'h00A0, 8'h5A);
  addRow("reset flags jp z",
         {8'h26, 8'h00, 8'h2E, 8'hA1, 8'h3E, 8'hA5, 8'hCA, 8'h0B, 8'h00, 8'h77, 8'h00,
          8'h3E, 8'h5A, 8'h77}, 14, -1, 16'h00A1, takenData(1'b1));
  // EI, EI then DI, neither; request pulse lands in the NOP run
  for (k = 0; k < 3; k++)
  begin
    mode0 = (k < 2) ? 8'hFB : 8'h00;
    mode1 = (k == 1) ? 8'hF3 : 8'h00;
    addRow($sformatf("interrupt mode %0d", k),
           {8'h26, 8'h00, 8'h2E, 8'hA2, 8'h3E, 8'hA5, mode0, mode1, {9{8'h00}}, 8'h77},
           18, 40, 16'h00A2, takenData(k == 0));
  end
endtask

// File: testbench/tbCpuCore.sv
`timescale 1ns/1ps

module tbCpuCore;
  import cpuPkg::*;

  logic                 iClock;
  logic                 reset;
  logic [dataWidth-1:0] readData;
  logic [intCount-1:0]  interruptRequests;
  logic [addrWidth-1:0] memAddr;
  logic [dataWidth-1:0] writeData;
  logic                 writeEnable;
  logic                 readRequest;

  logic [7:0] mem [256];
  int         errorCount  = 0;
  int         failedTests = 0;
  int         cycleCount  = 0;
  int         cycleLimit  = 0;

  `include "tbPrograms.svh"

  cpuCore u_cpuCore (
    .iClock            (iClock),
    .reset             (reset),
    .readData          (readData),
    .interruptRequests (interruptRequests),
    .memAddr           (memAddr),
    .writeData         (writeData),
    .writeEnable       (writeEnable),
    .readRequest       (readRequest)
  );

  initial
  begin
    iClock = 1'b0;
    forever #50 iClock = ~iClock;
  end

  // ------------------------------------------------------------------
  // Memory model with reads following the address
  assign readData = mem[memAddr[7:0]];

  always @(posedge iClock)
  begin
    if (writeEnable)
      mem[memAddr[7:0]] <= writeData;
  end

  task automatic loadMemory(input int row);
    int i;
    for (i = 0; i < 256; i++)
      mem[i] = i[7:0] ^ 8'hC5;
    mem[8'h48] = 8'h3E;  // Handler at vector 1 stores 5Ah to (HL)
    mem[8'h49] = 8'h5A;
    mem[8'h4A] = 8'h77;
    for (i = 0; i < progLen[row]; i++)
      mem[i] = progMem[row][i];
  endtask

  task automatic runRow(input int row);
    int   cycle;
    logic seen;
    logic readSeen;
    int   errorsBefore;
    errorsBefore = errorCount;
    @(posedge iClock);
    #1;
    reset = 1'b1;
    interruptRequests = '0;
    @(posedge iClock);  // Core held so the last row writes nothing more
    #1;
    loadMemory(row);
    repeat (4) @(posedge iClock);
    #1;
    check("readRequest", {15'h0000, readRequest}, 16'h0000);  // Low while in reset
    reset = 1'b0;
    cycle    = 0;
    seen     = 1'b0;
    readSeen = 1'b0;
    while (!seen)
    begin
      @(posedge iClock);
      #1;
      cycle++;
      interruptRequests = (cycle == pulseCycle[row]) ? 4'b0010 : 4'b0000;
      @(negedge iClock);
      seen     = writeEnable;
      readSeen = readSeen | readRequest;
    end
    // Opcode fetches come before any store
    check("readRequest", {15'h0000, readSeen}, 16'h0001);
    check("memAddr", memAddr, expAddr[row]);
    check("writeData", {8'h00, writeData}, {8'h00, expData[row]});
    if (errorCount == errorsBefore)
      $display("Test %0d %s: ok", row, testName[row]);
    else
    begin
      failedTests++;
      $display("Test %0d %s: bus mismatch", row, testName[row]);
    end
  endtask

  // ------------------------------------------------------------------
  // Whole-run cycle limit
  always @(posedge iClock)
  begin
    cycleCount <= cycleCount + 1;
    if (cycleLimit > 0 && cycleCount >= cycleLimit)
    begin
      $display("Timeout: no expected bus write within %0d clock cycles", cycleLimit);
      $display("Test failures found");
      $finish;
    end
  end

  initial
  begin
    reset = 1'b1;
    interruptRequests = '0;
    buildTable();
    cycleLimit = 40 * totalBytes;
    for (int row = 0; row < rowCount; row++)
      runRow(row);
    $display("Tests run %0d, passed %0d, failed %0d, mismatches %0d",
             rowCount, rowCount - failedTests, failedTests, errorCount);
    if (errorCount == 0)
      $display("All tests passed!");
    else
      $display("Test failures found");
    $finish;
  end

endmodule

// File: hw/cpuCore.sv
`timescale 1ns/1ps

module cpuCore (
  input  logic                         iClock,
  input  logic                         reset,
  input  logic [cpuPkg::dataWidth-1:0] readData,
  input  logic [cpuPkg::intCount-1:0]  interruptRequests,
  output logic [cpuPkg::addrWidth-1:0] memAddr,
  output logic [cpuPkg::dataWidth-1:0] writeData,
  output logic                         writeEnable,
  output logic                         readRequest
);
  import cpuPkg::*;

  logic [uPcWidth-1:0]  uPc, flowIndex;
  uopT                  uop;
  aluFuncT              aluFunc;
  logic                 flowEnable, latchOpcode;
  regSelT               readSel, writeSel;
  logic                 regWe, overwritePc, incPc, flagsWe, addrWe;
  logic [addrWidth-1:0] resultData, regData, vector;
  logic [dataWidth-1:0] newFlags, regA, flags;
  logic                 setEnable, enableValue, clearLatch, pending;

  // ------------------------------------------------------------------
  // Control
  flowSequencer u_flowSequencer (
    .iClock         (iClock),
    .reset          (reset),
    .currentUop     (uop),
    .flowIndex      (flowIndex),
    .interruptTaken (pending),
    .flags          (flags),
    .uPc            (uPc),
    .flowEnable     (flowEnable),
    .latchOpcode    (latchOpcode)
  );

  microcodeRom u_microcodeRom (
    .uPc       (uPc),
    .opcode    (readData),
    .uop       (uop),
    .flowIndex (flowIndex),
    .aluFunc   (aluFunc)
  );

  interruptControl u_interruptControl (
    .iClock      (iClock),
    .reset       (reset),
    .flowEnable  (flowEnable),
    .requests    (interruptRequests),
    .setEnable   (setEnable),
    .enableValue (enableValue),
    .clearLatch  (clearLatch),
    .pending     (pending),
    .vector      (vector)
  );

  // ------------------------------------------------------------------
  // Datapath
  aluFlags u_aluFlags (
    .iClock      (iClock),
    .reset       (reset),
    .uop         (uop),
    .flowEnable  (flowEnable),
    .latchOpcode (latchOpcode),
    .aluFunc     (aluFunc),
    .regData     (regData),
    .regA        (regA),
    .flags       (flags),
    .vector      (vector),
    .readSel     (readSel),
    .writeSel    (writeSel),
    .regWe       (regWe),
    .resultData  (resultData),
    .overwritePc (overwritePc),
    .incPc       (incPc),
    .flagsWe     (flagsWe),
    .newFlags    (newFlags),
    .addrWe      (addrWe),
    .writeEnable (writeEnable),
    .readRequest (readRequest),
    .setEnable   (setEnable),
    .enableValue (enableValue),
    .clearLatch  (clearLatch)
  );

  registerFile u_registerFile (
    .iClock      (iClock),
    .reset       (reset),
    .flowEnable  (flowEnable),
    .readSel     (readSel),
    .writeSel    (writeSel),
    .regWe       (regWe),
    .resultData  (resultData),
    .overwritePc (overwritePc),
    .incPc       (incPc),
    .flagsWe     (flagsWe),
    .newFlags    (newFlags),
    .addrWe      (addrWe),
    .readData    (readData),
    .regData     (regData),
    .regA        (regA),
    .flags       (flags),
    .memAddr     (memAddr),
    .writeData   (writeData)
  );

endmodule

// File: hw/interruptControl.sv
`timescale 1ns/1ps

module interruptControl (
  input  logic                         iClock,
  input  logic                         reset,
  input  logic                         flowEnable,
  input  logic [cpuPkg::intCount-1:0]  requests,
  input  logic                         setEnable,
  input  logic                         enableValue,
  input  logic                         clearLatch,
  output logic                         pending,
  output logic [cpuPkg::addrWidth-1:0] vector
);
  import cpuPkg::*;

  logic [intCount-1:0] latched;
  logic                enabled;
  logic                taken;

  assign taken = flowEnable && clearLatch;

  always_ff @(posedge iClock)
  begin
    if (reset)
    begin
      latched <= '0;
      enabled <= 1'b0;
    end
    else
    begin
      latched <= (taken ? '0 : latched) | requests;  // New requests still caught
      if (taken)
        enabled <= 1'b0;
      else if (flowEnable && setEnable)
        enabled <= enableValue;
    end
  end

  assign pending = enabled && |latched;

  // Lowest set bit wins
  always_comb
  begin
    vector = intVectors[intCount-1];
    for (int i = intCount - 1; i >= 0; i--)
      if (latched[i])
        vector = intVectors[i];
  end

endmodule

// File: hw/aluFlags.sv
`timescale 1ns/1ps

module aluFlags (
  input  logic                         iClock,
  input  logic                         reset,
  input  cpuPkg::uopT                  uop,
  input  logic                         flowEnable,
  input  logic                         latchOpcode,
  input  cpuPkg::aluFuncT              aluFunc,
  input  logic [cpuPkg::addrWidth-1:0] regData,
  input  logic [cpuPkg::dataWidth-1:0] regA,
  input  logic [cpuPkg::dataWidth-1:0] flags,
  input  logic [cpuPkg::addrWidth-1:0] vector,
  output cpuPkg::regSelT               readSel,
  output cpuPkg::regSelT               writeSel,
  output logic                         regWe,
  output logic [cpuPkg::addrWidth-1:0] resultData,
  output logic                         overwritePc,
  output logic                         incPc,
  output logic                         flagsWe,
  output logic [cpuPkg::dataWidth-1:0] newFlags,
  output logic                         addrWe,
  output logic                         writeEnable,
  output logic                         readRequest,
  output logic                         setEnable,
  output logic                         enableValue,
  output logic                         clearLatch
);
  import cpuPkg::*;

  regSelT               opSel;
  logic                 opAlt;
  aluFuncT              aluFuncReg;
  logic [dataWidth:0]   sum, diff;
  logic [4:0]           halfSum, halfDiff;
  logic [dataWidth-1:0] aluResult;
  logic                 zero;

  assign opSel = regSelT'(uop.operand[3:0]);
  assign opAlt = uop.operand[opAltBit];

  always_ff @(posedge iClock)
  begin
    if (reset)
    begin
      aluFuncReg  <= aluPass;
      readRequest <= 1'b0;
    end
    else
    begin
      if (latchOpcode)
        aluFuncReg <= aluFunc;
      readRequest <= flowEnable && uop.cmd == sma;
    end
  end

  // ------------------------------------------------------------------
  // 8-bit datapath, A against the selected register
  assign sum      = {1'b0, regA} + {1'b0, regData[7:0]};
  assign diff     = {1'b0, regA} - {1'b0, regData[7:0]};
  assign halfSum  = {1'b0, regA[3:0]} + {1'b0, regData[3:0]};
  assign halfDiff = {1'b0, regA[3:0]} - {1'b0, regData[3:0]};

  always_comb
  begin
    case (aluFuncReg)
      aluAdd:  aluResult = sum[7:0];
      aluSub:  aluResult = diff[7:0];
      aluAnd:  aluResult = regA & regData[7:0];
      aluXor:  aluResult = regA ^ regData[7:0];
      default: aluResult = regData[7:0];
    endcase
  end

  always_comb
  begin
    readSel     = opSel;
    writeSel    = opSel;
    regWe       = 1'b0;
    resultData  = '0;
    overwritePc = 1'b0;
    addrWe      = 1'b0;
    setEnable   = 1'b0;
    enableValue = 1'b0;
    clearLatch  = 1'b0;
    case (uop.cmd)
      sma: addrWe = 1'b1;
      srm:
      begin
        readSel    = memData;
        regWe      = 1'b1;
        resultData = {8'h00, regData[7:0]};
      end
      aluOp:
      begin
        regWe      = !opAlt;  // Fetch jump writes nothing
        writeSel   = a;
        resultData = {8'h00, aluResult};
      end
      inc8:
      begin
        regWe      = 1'b1;
        resultData = {8'h00, regData[7:0] + 8'd1};
      end
      dec8:
      begin
        regWe      = 1'b1;
        resultData = {8'h00, regData[7:0] - 8'd1};
      end
      sx16r:
      begin
        writeSel   = scratch;
        regWe      = 1'b1;
        resultData = {8'h00, opAlt ? regData[15:8] : regData[7:0]};
      end
      spc:
      begin
        overwritePc = 1'b1;
        resultData  = regData;
      end
      jint:
      begin
        overwritePc = 1'b1;
        resultData  = vector;
        clearLatch  = 1'b1;
      end
      seti:
      begin
        setEnable   = 1'b1;
        enableValue = 1'b1;
      end
      ceti: setEnable = 1'b1;
      default: ;
    endcase
  end

  assign writeEnable = flowEnable && uop.cmd == smw;
  assign incPc       = uop.incPc;
  assign flagsWe     = uop.flagsUpdate;

  // ------------------------------------------------------------------
  // Flag rules
  assign zero = (resultData[7:0] == 8'h00);

  always_comb
  begin
    newFlags = {flags[7:4], 4'h0};
    case (uop.cmd)
      inc8: {newFlags[flagZ], newFlags[flagN], newFlags[flagH]} =
              {zero, 1'b0, resultData[3:0] == 4'h0};
      dec8: {newFlags[flagZ], newFlags[flagN], newFlags[flagH]} =
              {zero, 1'b1, resultData[3:0] == 4'hF};
      aluOp:
      begin
        case (aluFuncReg)
          aluAdd:  newFlags[7:4] = {zero, 1'b0, halfSum[4], sum[8]};
          aluSub:  newFlags[7:4] = {zero, 1'b1, halfDiff[4], diff[8]};  // Borrows
          aluAnd:  newFlags[7:4] = {zero, 1'b0, 1'b1, 1'b0};
          aluXor:  newFlags[7:4] = {zero, 1'b0, 1'b0, 1'b0};
          default: ;
        endcase
      end
      default: ;
    endcase
  end

endmodule

// File: hw/registerFile.sv
`timescale 1ns/1ps

module registerFile (
  input  logic                         iClock,
  input  logic                         reset,
  input  logic                         flowEnable,
  input  cpuPkg::regSelT               readSel,
  input  cpuPkg::regSelT               writeSel,
  input  logic                         regWe,
  input  logic [cpuPkg::addrWidth-1:0] resultData,
  input  logic                         overwritePc,
  input  logic                         incPc,
  input  logic                         flagsWe,
  input  logic [cpuPkg::dataWidth-1:0] newFlags,
  input  logic                         addrWe,
  input  logic [cpuPkg::dataWidth-1:0] readData,
  output logic [cpuPkg::addrWidth-1:0] regData,
  output logic [cpuPkg::dataWidth-1:0] regA,
  output logic [cpuPkg::dataWidth-1:0] flags,
  output logic [cpuPkg::addrWidth-1:0] memAddr,
  output logic [cpuPkg::dataWidth-1:0] writeData
);
  import cpuPkg::*;

  logic [dataWidth-1:0] regB, regH, regL;
  logic [addrWidth-1:0] pc, scratchReg;
  regSelT               addrSel;
  logic                 weA, weB, weH, weL, weScratch;

  function automatic logic [addrWidth-1:0] selectReg(regSelT sel);
    case (sel)
      a:        selectReg = {8'h00, regA};
      b:        selectReg = {8'h00, regB};
      h:        selectReg = {8'h00, regH};
      l:        selectReg = {8'h00, regL};
      hl:       selectReg = {regH, regL};
      pcReg:    selectReg = pc;
      pcHigh:   selectReg = {8'h00, pc[15:8]};
      flagsReg: selectReg = {8'h00, flags};
      scratch:  selectReg = scratchReg;
      memData:  selectReg = {8'h00, readData};
      default:  selectReg = '0;
    endcase
  endfunction

  // hl writes both halves
  assign weA       = regWe && writeSel == a;
  assign weB       = regWe && writeSel == b;
  assign weH       = regWe && (writeSel == h || writeSel == hl);
  assign weL       = regWe && (writeSel == l || writeSel == hl);
  assign weScratch = regWe && writeSel == scratch;

  always_comb
  begin
    regData = selectReg(readSel);
    memAddr = selectReg(addrSel);  // Follows the register live
  end

  assign writeData = regData[7:0];

  always_ff @(posedge iClock)
  begin
    if (reset)
    begin
      regA       <= '0;
      regB       <= '0;
      regH       <= '0;
      regL       <= '0;
      flags      <= flagsReset;
      pc         <= pcReset;
      scratchReg <= '0;
      addrSel    <= pcReg;
    end
    else if (flowEnable)
    begin
      if (weA)
        regA <= resultData[7:0];
      if (weB)
        regB <= resultData[7:0];
      if (weH)
        regH <= (writeSel == hl) ? resultData[15:8] : resultData[7:0];
      if (weL)
        regL <= resultData[7:0];
      if (weScratch)
        scratchReg <= {resultData[7:0], scratchReg[15:8]};  // Byte enters at the top
      if (flagsWe)
        flags <= {newFlags[7:4], 4'h0};
      if (overwritePc)
        pc <= resultData;
      else if (incPc)
        pc <= pc + 1'b1;
      if (addrWe)
        addrSel <= readSel;
    end
  end

endmodule

// File: hw/microcodeRom.sv
`timescale 1ns/1ps

module microcodeRom (
  input  logic [cpuPkg::uPcWidth-1:0]  uPc,
  input  logic [cpuPkg::dataWidth-1:0] opcode,
  output cpuPkg::uopT                  uop,
  output logic [cpuPkg::uPcWidth-1:0]  flowIndex,
  output cpuPkg::aluFuncT              aluFunc
);
  import cpuPkg::*;

  function automatic uopT mkUop(logic incPc, eofT eofCode, logic flagsUpdate, uCmdT cmd,
                                regSelT sel, logic alt);
    mkUop = {1'b0, incPc, eofCode, flagsUpdate, cmd, alt, sel};
  endfunction

  // ------------------------------------------------------------------
  // Opcode lookup
  always_comb
  begin
    case (opcode)
      opLdA:            flowIndex = flowLdA;
      opLdB:            flowIndex = flowLdB;
      opLdH:            flowIndex = flowLdH;
      opLdL:            flowIndex = flowLdL;
      opIncA:           flowIndex = flowIncA;
      opDecA:           flowIndex = flowDecA;
      opAddB, opSubB,
      opAndB, opXorB:   flowIndex = flowAlu;  // Shared, aluFunc picks the operation
      opLdHlA:          flowIndex = flowStore;
      opJp:             flowIndex = flowJp;
      opJpZ:            flowIndex = flowJpZ;
      opJpC:            flowIndex = flowJpC;
      opEi:             flowIndex = flowEi;
      opDi:             flowIndex = flowDi;
      default:          flowIndex = flowNop;
    endcase
  end

  always_comb
  begin
    case (opcode)
      opAddB:  aluFunc = aluAdd;
      opSubB:  aluFunc = aluSub;
      opAndB:  aluFunc = aluAnd;
      opXorB:  aluFunc = aluXor;
      default: aluFunc = aluPass;
    endcase
  end

  // ------------------------------------------------------------------
  // Micro-flows
  always_comb
  begin
    case (uPc)
      flowFetch:     uop = mkUop(1'b0, op,    1'b0, sma,   pcReg,   1'b0);
      flowFetch + 1: uop = mkUop(1'b1, op,    1'b0, aluOp, a,       1'b1); // To opcode flow
      flowInterrupt: uop = mkUop(1'b0, eof,   1'b0, jint,  pcReg,   1'b0);
      flowLdA:       uop = mkUop(1'b1, eof,   1'b0, srm,   a,       1'b0);
      flowLdB:       uop = mkUop(1'b1, eof,   1'b0, srm,   b,       1'b0);
      flowLdH:       uop = mkUop(1'b1, eof,   1'b0, srm,   h,       1'b0);
      flowLdL:       uop = mkUop(1'b1, eof,   1'b0, srm,   l,       1'b0);
      flowIncA:      uop = mkUop(1'b0, eof,   1'b1, inc8,  a,       1'b0);
      flowDecA:      uop = mkUop(1'b0, eof,   1'b1, dec8,  a,       1'b0);
      flowAlu:       uop = mkUop(1'b0, eof,   1'b1, aluOp, b,       1'b0);
      flowStore:     uop = mkUop(1'b0, op,    1'b0, sma,   hl,      1'b0);
      flowStore + 1: uop = mkUop(1'b0, eof,   1'b0, smw,   a,       1'b0);
      // Operand bytes low first into scratch
      flowJp:        uop = mkUop(1'b1, op,    1'b0, sx16r, memData, 1'b0);
      flowJp + 1:    uop = mkUop(1'b1, op,    1'b0, sx16r, memData, 1'b0);
      flowJp + 2:    uop = mkUop(1'b0, eof,   1'b0, spc,   scratch, 1'b0);
      flowJpZ:       uop = mkUop(1'b1, op,    1'b0, sx16r, memData, 1'b0);
      flowJpZ + 1:   uop = mkUop(1'b1, eofNz, 1'b0, sx16r, memData, 1'b0);
      flowJpZ + 2:   uop = mkUop(1'b0, eof,   1'b0, spc,   scratch, 1'b0);
      flowJpC:       uop = mkUop(1'b1, op,    1'b0, sx16r, memData, 1'b0);
      flowJpC + 1:   uop = mkUop(1'b1, eofNc, 1'b0, sx16r, memData, 1'b0);
      flowJpC + 2:   uop = mkUop(1'b0, eof,   1'b0, spc,   scratch, 1'b0);
      flowEi:        uop = mkUop(1'b0, eof,   1'b0, seti,  a,       1'b0);
      flowDi:        uop = mkUop(1'b0, eof,   1'b0, ceti,  a,       1'b0);
      default:       uop = mkUop(1'b0, eof,   1'b0, nop,   a,       1'b0); // NOP flow
    endcase
  end

endmodule

// File: hw/flowSequencer.sv
`timescale 1ns/1ps

module flowSequencer (
  input  logic                         iClock,
  input  logic                         reset,
  input  cpuPkg::uopT                  currentUop,
  input  logic [cpuPkg::uPcWidth-1:0]  flowIndex,
  input  logic                         interruptTaken,
  input  logic [cpuPkg::dataWidth-1:0] flags,
  output logic [cpuPkg::uPcWidth-1:0]  uPc,
  output logic                         flowEnable,
  output logic                         latchOpcode
);
  import cpuPkg::*;

  seqStateT state;
  seqStateT nextState;
  logic     endOfFlow;

  // ------------------------------------------------------------------
  // Flow state machine
  always_ff @(posedge iClock)
  begin
    if (reset)
      state <= afterReset;
    else
      state <= nextState;
  end

  always_comb
  begin
    case (state)
      afterReset: nextState = startFlow;
      startFlow:  nextState = runFlow;
      runFlow:    nextState = endOfFlow ? endFlow : runFlow;
      endFlow:    nextState = startFlow;
      default:    nextState = afterReset;
    endcase
  end

  // Conditional codes end the flow early
  always_comb
  begin
    case (currentUop.eofCode)
      eof:     endOfFlow = 1'b1;
      eofC:    endOfFlow = flags[flagC];
      eofNc:   endOfFlow = !flags[flagC];
      eofZ:    endOfFlow = flags[flagZ];
      eofNz:   endOfFlow = !flags[flagZ];
      default: endOfFlow = 1'b0;
    endcase
  end

  assign flowEnable = (state == runFlow);

  // Fetch jump is an aluOp with the lookup flag set
  assign latchOpcode = flowEnable && currentUop.cmd == aluOp
                       && currentUop.operand[opAltBit];

  // ------------------------------------------------------------------
  // Micro-PC
  always_ff @(posedge iClock)
  begin
    if (reset)
      uPc <= flowFetch;
    else if (state == startFlow)
      uPc <= interruptTaken ? flowInterrupt : flowFetch;
    else if (latchOpcode)
      uPc <= flowIndex;
    else if (flowEnable)
      uPc <= uPc + 1'b1;
  end

endmodule

// File: hw/cpuPkg.sv
package cpuPkg;

  localparam int dataWidth = 8;
  localparam int addrWidth = 16;
  localparam int uPcWidth  = 6;
  localparam int intCount  = 4;
  localparam int opAltBit  = 4;  // Operand bit 4 marks a lookup target or a high byte

  // ------------------------------------------------------------------
  // Micro-op layout
  typedef enum logic [2:0] {op, eof, eofC, eofNc, eofZ, eofNz} eofT;

  typedef enum logic [4:0] {
    nop, sma, srm, smw, aluOp, inc8, dec8, sx16r, spc, jint, seti, ceti
  } uCmdT;

  typedef enum logic [3:0] {
    a, b, h, l, hl, pcReg, pcHigh, flagsReg, scratch, memData
  } regSelT;

  typedef enum logic [2:0] {aluPass, aluAdd, aluSub, aluAnd, aluXor} aluFuncT;

  typedef enum logic [1:0] {afterReset, startFlow, runFlow, endFlow} seqStateT;

  typedef struct packed {
    logic       reserved;
    logic       incPc;
    eofT        eofCode;
    logic       flagsUpdate;
    uCmdT       cmd;
    logic [4:0] operand;   // {alt, regSelT}
  } uopT;

  // Flag bits, low nibble always zero
  localparam int flagZ = 7;
  localparam int flagN = 6;
  localparam int flagH = 5;
  localparam int flagC = 4;

  localparam logic [dataWidth-1:0] flagsReset = 8'hB0;
  localparam logic [addrWidth-1:0] pcReset    = 16'h0000;

  // Request bit 0 first
  localparam logic [intCount-1:0][addrWidth-1:0] intVectors =
    {16'h0060, 16'h0050, 16'h0048, 16'h0040};

  // ------------------------------------------------------------------
  // Micro-flow entry points
  localparam logic [uPcWidth-1:0] flowFetch     = 6'd0;
  localparam logic [uPcWidth-1:0] flowInterrupt = 6'd2;
  localparam logic [uPcWidth-1:0] flowNop       = 6'd3;
  localparam logic [uPcWidth-1:0] flowLdA       = 6'd4;
  localparam logic [uPcWidth-1:0] flowLdB       = 6'd5;
  localparam logic [uPcWidth-1:0] flowLdH       = 6'd6;
  localparam logic [uPcWidth-1:0] flowLdL       = 6'd7;
  localparam logic [uPcWidth-1:0] flowIncA      = 6'd8;
  localparam logic [uPcWidth-1:0] flowDecA      = 6'd9;
  localparam logic [uPcWidth-1:0] flowAlu       = 6'd10;
  localparam logic [uPcWidth-1:0] flowStore     = 6'd11;
  localparam logic [uPcWidth-1:0] flowJp        = 6'd13;
  localparam logic [uPcWidth-1:0] flowJpZ       = 6'd16;
  localparam logic [uPcWidth-1:0] flowJpC       = 6'd19;
  localparam logic [uPcWidth-1:0] flowEi        = 6'd22;
  localparam logic [uPcWidth-1:0] flowDi        = 6'd23;

  // Opcodes
  localparam logic [dataWidth-1:0] opNop   = 8'h00;
  localparam logic [dataWidth-1:0] opLdB   = 8'h06;
  localparam logic [dataWidth-1:0] opLdH   = 8'h26;
  localparam logic [dataWidth-1:0] opLdL   = 8'h2E;
  localparam logic [dataWidth-1:0] opLdA   = 8'h3E;
  localparam logic [dataWidth-1:0] opIncA  = 8'h3C;
  localparam logic [dataWidth-1:0] opDecA  = 8'h3D;
  localparam logic [dataWidth-1:0] opAddB  = 8'h80;
  localparam logic [dataWidth-1:0] opSubB  = 8'h90;
  localparam logic [dataWidth-1:0] opAndB  = 8'hA0;
  localparam logic [dataWidth-1:0] opXorB  = 8'hA8;
  localparam logic [dataWidth-1:0] opLdHlA = 8'h77;
  localparam logic [dataWidth-1:0] opJp    = 8'hC3;
  localparam logic [dataWidth-1:0] opJpZ   = 8'hCA;
  localparam logic [dataWidth-1:0] opJpC   = 8'hDA;
  localparam logic [dataWidth-1:0] opEi    = 8'hFB;
  localparam logic [dataWidth-1:0] opDi    = 8'hF3;

endpackage
